// ==== src.f ====
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/line_port_if.sv
rtl/cache_ctrl.sv
rtl/cache_data.sv
rtl/cache_top.sv
test/tb_clock.sv
test/cache_assert.sv
test/cache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cache_tb -f src.f

status=0
out=$(./obj_dir/Vcache_tb 2>&1) || status=$?
printf '%s\n' "$out"

# the run counts only if the simulation itself ended cleanly
if [ "$status" -eq 0 ] && grep -qx 'Test passed' <<< "$out"; then
   exit 0
fi
exit 1

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
/* data cache testbench */
module cache_tb
   import cache_geom_pkg::*;
();

   localparam int num_ops       = 2000;
   localparam int cycles_per_op = 60;
   localparam int reset_cycles  = 10;

   logic              clk;
   logic              rst;
   logic              req_valid;
   logic              req_write;
   logic [addr_w-1:0] req_addr;
   logic [word_w-1:0] req_wdata;
   logic              req_ready;
   logic              resp_valid;
   logic [word_w-1:0] resp_rdata;
   logic              mem_req_valid;
   logic              mem_req_write;
   logic [addr_w-1:0] mem_req_addr;
   logic [line_w-1:0] mem_wdata;
   logic              mem_req_ready;
   logic              mem_rdata_valid;
   logic [line_w-1:0] mem_rdata;

   // stimulus and memory delays use separate streams
   integer seed     = 32'hdcbd;
   integer mem_seed = 32'hdcbd;

   // architectural word values, by word address
   logic [word_w-1:0] ref_words [logic [addr_w-1:0]];
   // start contents and written-back lines, by line address
   logic [line_w-1:0] init_lines [logic [addr_w-1:0]];
   logic [line_w-1:0] main_mem [logic [addr_w-1:0]];
   // expected cache contents
   logic [tag_w-1:0]     model_tag [num_lines];
   logic [num_lines-1:0] model_valid;
   logic [num_lines-1:0] model_dirty;

   addr_t pend_addr;
   int mem_reads = 0;
   int mem_writes = 0;
   int word_errors = 0;
   int line_errors = 0;
   int addr_errors = 0;
   int flag_errors = 0;
   int other_errors = 0;

   tb_clock u_clock (.clk(clk));

   cache_top u_cache_top (
      .clk (clk), .rst (rst),
      .req_valid (req_valid), .req_write (req_write),
      .req_addr (req_addr), .req_wdata (req_wdata), .req_ready (req_ready),
      .resp_valid (resp_valid), .resp_rdata (resp_rdata),
      .mem_req_valid (mem_req_valid), .mem_req_write (mem_req_write),
      .mem_req_addr (mem_req_addr), .mem_wdata (mem_wdata),
      .mem_req_ready (mem_req_ready), .mem_rdata_valid (mem_rdata_valid),
      .mem_rdata (mem_rdata)
   );

   // four tags over eight indices, so lines conflict often
   function automatic logic [tag_w-1:0] pick_tag(input logic [1:0] sel);
      case (sel)
         2'd0: return 20'h00000;
         2'd1: return 20'h00001;
         2'd2: return 20'h8a5c3;
         default: return 20'hfffff;
      endcase
   endfunction

   function automatic logic [index_w-1:0] pick_index(input logic [2:0] sel);
      logic [index_w-1:0] table_idx [8] = '{8'h00, 8'h01, 8'h3c, 8'h55,
                                            8'h7f, 8'h80, 8'haa, 8'hff};
      return table_idx[sel];
   endfunction

   // memory wait of 0 to 5 cycles
   function automatic int mem_delay();
      logic [31:0] r;
      r = $random(mem_seed);
      return int'(r % 6);
   endfunction

   task automatic check_word(input string name, input logic [word_w-1:0] got,
                             input logic [word_w-1:0] exp);
      if (got !== exp) begin
         word_errors++;
         $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_line(input string name, input logic [line_w-1:0] got,
                             input logic [line_w-1:0] exp);
      if (got !== exp) begin
         line_errors++;
         $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got.raw !== exp.raw) begin
         addr_errors++;
         $display("** Error %s: got %h, expected %h at %0t", name, got.raw, exp.raw,
                  $time);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errors++;
         $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // random start data for every line the test can touch
   task automatic fill_memory();
      addr_t             a;
      logic [line_w-1:0] l;
      int                t;
      int                x;
      int                w;
      for (t = 0; t < 4; t++) begin
         for (x = 0; x < 8; x++) begin
            a.raw           = '0;
            a.fields.tag    = pick_tag(t[1:0]);
            a.fields.index  = pick_index(x[2:0]);
            for (w = 0; w < 4; w++) begin
               l[w*word_w +: word_w] = $random(seed);
               ref_words[(a.raw >> 2) + w] = l[w*word_w +: word_w];
            end
            init_lines[a.raw >> offset_w] = l;
         end
      end
   endtask

   // one request from issue to response, against the cache model
   task automatic run_access(input logic wr, input addr_t a, input logic [word_w-1:0] wd);
      logic [index_w-1:0] idx;
      logic               exp_hit;
      logic               exp_wb;
      int                 reads_before;
      int                 writes_before;
      int                 cycles;
      idx           = a.fields.index;
      exp_hit       = model_valid[idx] && (model_tag[idx] == a.fields.tag);
      exp_wb        = !exp_hit && model_valid[idx] && model_dirty[idx];
      reads_before  = mem_reads;
      writes_before = mem_writes;
      pend_addr     = a;
      req_valid <= 1'b1;
      req_write <= wr;
      req_addr  <= a.raw;
      req_wdata <= wd;
      do @(posedge clk); while (!req_ready);
      req_valid <= 1'b0;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!resp_valid);
      if (wr) begin
         check_word("resp_rdata", resp_rdata, '0);
         ref_words[a.raw >> 2] = wd;
      end else begin
         check_word("resp_rdata", resp_rdata, ref_words[a.raw >> 2]);
      end
      // a hit answers in two cycles with the memory untouched
      if (exp_hit) begin
         check_word("resp_valid latency", cycles, 2);
      end
      check_word("refill reads", mem_reads - reads_before, exp_hit ? 0 : 1);
      check_word("write-backs", mem_writes - writes_before, exp_wb ? 1 : 0);
      if (!exp_hit) begin
         model_valid[idx] = 1'b1;
         model_tag[idx]   = a.fields.tag;
         model_dirty[idx] = 1'b0;
      end
      if (wr) begin
         model_dirty[idx] = 1'b1;
      end
   endtask

   // main memory with random ready and data delays
   initial begin
      int                ready_wait;
      int                data_wait;
      int                w;
      logic [addr_w-1:0] rd_key;
      logic [addr_w-1:0] base;
      addr_t             got_a;
      addr_t             exp_a;
      logic [line_w-1:0] exp_line;
      mem_req_ready   = 1'b0;
      mem_rdata_valid = 1'b0;
      mem_rdata       = '0;
      ready_wait      = -1;
      data_wait       = -1;
      rd_key          = '0;
      forever begin
         @(posedge clk);
         mem_req_ready   <= 1'b0;
         mem_rdata_valid <= 1'b0;
         if (!rst) begin
            ready_wait = -1;
            data_wait  = -1;
         end else begin
            if (data_wait == 0) begin
               mem_rdata_valid <= 1'b1;
               if (main_mem.exists(rd_key)) begin
                  mem_rdata <= main_mem[rd_key];
               end else if (init_lines.exists(rd_key)) begin
                  mem_rdata <= init_lines[rd_key];
               end else begin
                  other_errors++;
                  $display("refill read from a line the test never used at %0t", $time);
               end
               data_wait = -1;
            end else if (data_wait > 0) begin
               data_wait--;
            end
            if (mem_req_valid && mem_req_ready) begin
               got_a.raw         = mem_req_addr;
               exp_a.raw         = '0;
               exp_a.fields.index = pend_addr.fields.index;
               ready_wait        = -1;
               if (mem_req_write) begin
                  // victim line must hold the current word values
                  exp_a.fields.tag = model_tag[pend_addr.fields.index];
                  check_addr("mem_req_addr", got_a, exp_a);
                  base = mem_req_addr >> 2;
                  if (ref_words.exists(base)) begin
                     for (w = 0; w < 4; w++) begin
                        exp_line[w*word_w +: word_w] = ref_words[base + w];
                     end
                     check_line("mem_wdata", mem_wdata, exp_line);
                  end else begin
                     other_errors++;
                     $display("write-back to a line the test never used at %0t", $time);
                  end
                  main_mem[mem_req_addr >> offset_w] = mem_wdata;
                  mem_writes++;
               end else begin
                  exp_a.fields.tag = pend_addr.fields.tag;
                  check_addr("mem_req_addr", got_a, exp_a);
                  rd_key    = mem_req_addr >> offset_w;
                  data_wait = mem_delay();
                  mem_reads++;
               end
            end else if (mem_req_valid) begin
               if (ready_wait < 0) begin
                  ready_wait = mem_delay();
               end
               if (ready_wait == 0) begin
                  mem_req_ready <= 1'b1;
               end else begin
                  ready_wait--;
               end
            end
         end
      end
   end

   // reset, random traffic, closing report
   initial begin
      addr_t             a;
      logic [31:0]       r;
      logic [word_w-1:0] wd;
      int                i;
      rst         = 1'b0;
      req_valid   = 1'b0;
      req_write   = 1'b0;
      req_addr    = '0;
      req_wdata   = '0;
      model_valid = '0;
      model_dirty = '0;
      pend_addr   = '0;
      fill_memory();
      repeat (reset_cycles) @(posedge clk);
      rst <= 1'b1;
      repeat (2) @(posedge clk);
      check_flag("req_ready", req_ready, 1'b1);
      check_flag("resp_valid", resp_valid, 1'b0);
      check_flag("mem_req_valid", mem_req_valid, 1'b0);
      for (i = 0; i < num_ops; i++) begin
         r                = $random(seed);
         wd               = $random(seed);
         a.raw            = '0;
         a.fields.tag     = pick_tag(r[1:0]);
         a.fields.index   = pick_index(r[4:2]);
         a.fields.offset  = {r[6:5], 2'b00};
         // short idle gaps between requests
         repeat (r[9:8]) @(posedge clk);
         run_access(r[7], a, wd);
      end
      repeat (4) @(posedge clk);
      $display("errors: word %0d, line %0d, addr %0d, flag %0d, other %0d",
               word_errors, line_errors, addr_errors, flag_errors, other_errors);
      if (word_errors + line_errors + addr_errors + flag_errors + other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog, generous bound per request
   initial begin
      repeat (reset_cycles + num_ops * cycles_per_op) @(posedge clk);
      $display("timeout: the cache did not finish %0d requests in time", num_ops);
      $display("Test failed");
      $finish;
   end

endmodule
`default_nettype wire

// ==== test/cache_assert.sv ====
`timescale 1ns/1ps
`default_nettype none
/* cache handshake assertions */
module cache_assert
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;
(
   input logic              clk,
   input logic              rst,
   input ctrl_state_t       state,
   input logic              req_valid,
   input logic              req_ready,
   input logic              resp_valid,
   input logic              mem_req_valid,
   input logic              mem_req_ready,
   input logic              mem_req_write,
   input logic [addr_w-1:0] mem_req_addr,
   input logic [line_w-1:0] mem_wdata
);

   // memory request stays up with the same payload until taken
   a_mem_hold: assert property (@(posedge clk) disable iff (!rst)
      mem_req_valid && !mem_req_ready |=>
         mem_req_valid && $stable(mem_req_write) && $stable(mem_req_addr))
      else $error("memory request dropped or changed before accept");

   // victim data held while the write-back waits
   a_wdata_hold: assert property (@(posedge clk) disable iff (!rst)
      mem_req_valid && mem_req_write && !mem_req_ready |=> $stable(mem_wdata))
      else $error("write-back data changed before accept");

   // one response pulse per request
   a_resp_pulse: assert property (@(posedge clk) disable iff (!rst)
      resp_valid |=> !resp_valid)
      else $error("resp_valid high for two cycles in a row");

   // taken request leaves idle and drops ready
   a_ready_idle: assert property (@(posedge clk) disable iff (!rst)
      req_valid && req_ready |=> state == lookup && !req_ready)
      else $error("req_ready still high after a request was taken");

endmodule

bind cache_top cache_assert u_assert (
   .clk           (clk),
   .rst           (rst),
   .state         (u_ctrl.state),
   .req_valid     (req_valid),
   .req_ready     (req_ready),
   .resp_valid    (resp_valid),
   .mem_req_valid (mem_req_valid),
   .mem_req_ready (mem_req_ready),
   .mem_req_write (mem_req_write),
   .mem_req_addr  (mem_req_addr),
   .mem_wdata     (mem_wdata)
);
`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none
/* testbench clock */
module tb_clock (
   output logic clk
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

endmodule
`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none
/* write-back data cache top */
module cache_top
   import cache_geom_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   // processor request
   input  logic              req_valid,
   input  logic              req_write,
   input  logic [addr_w-1:0] req_addr,
   input  logic [word_w-1:0] req_wdata,
   output logic              req_ready,
   // processor response
   output logic              resp_valid,
   output logic [word_w-1:0] resp_rdata,
   // memory request
   output logic              mem_req_valid,
   output logic              mem_req_write,
   output logic [addr_w-1:0] mem_req_addr,
   output logic [line_w-1:0] mem_wdata,
   input  logic              mem_req_ready,
   // memory refill data
   input  logic              mem_rdata_valid,
   input  logic [line_w-1:0] mem_rdata
);

   line_port_if line_bus ();

   cache_ctrl u_ctrl (
      .clk             (clk),
      .rst             (rst),
      .req_valid       (req_valid),
      .req_write       (req_write),
      .req_addr        (req_addr),
      .req_wdata       (req_wdata),
      .req_ready       (req_ready),
      .resp_valid      (resp_valid),
      .resp_rdata      (resp_rdata),
      .mem_req_valid   (mem_req_valid),
      .mem_req_write   (mem_req_write),
      .mem_req_addr    (mem_req_addr),
      .mem_req_ready   (mem_req_ready),
      .mem_rdata_valid (mem_rdata_valid),
      .mem_rdata       (mem_rdata),
      .line            (line_bus)
   );

   cache_data u_data (
      .clk  (clk),
      .line (line_bus)
   );

   // victim line, stable through write-back since index is held
   assign mem_wdata = line_bus.line_rdata;

endmodule
`default_nettype wire

// ==== rtl/cache_data.sv ====
`timescale 1ns/1ps
`default_nettype none
/* cache line storage */
module cache_data
   import cache_geom_pkg::*;
(
   input  logic       clk,
   line_port_if.store line
);

   // line contents
   logic [line_w-1:0] lines [num_lines];

   // current line with one word replaced
   logic [line_w-1:0] merged;

   always_comb begin
      merged = lines[line.index];
      merged[line.word_sel*word_w +: word_w] = line.word_wdata;
   end

   // writes at the edge, fill and word write never together
   always_ff @(posedge clk) begin
      if (line.fill_we) begin
         lines[line.index] <= line.fill_line;
      end else if (line.word_we) begin
         lines[line.index] <= merged;
      end
   end

   // registered read of the indexed line
   // a fill is passed straight through so the next lookup sees new data
   always_ff @(posedge clk) begin
      if (line.fill_we) begin
         line.line_rdata <= line.fill_line;
      end else begin
         line.line_rdata <= lines[line.index];
      end
   end

endmodule
`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
/* cache controller */
module cache_ctrl
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   // processor side
   input  logic              req_valid,
   input  logic              req_write,
   input  logic [addr_w-1:0] req_addr,
   input  logic [word_w-1:0] req_wdata,
   output logic              req_ready,
   output logic              resp_valid,
   output logic [word_w-1:0] resp_rdata,
   // memory side
   output logic              mem_req_valid,
   output logic              mem_req_write,
   output logic [addr_w-1:0] mem_req_addr,
   input  logic              mem_req_ready,
   input  logic              mem_rdata_valid,
   input  logic [line_w-1:0] mem_rdata,
   // data array
   line_port_if.ctrl         line
);

   // tag store, one entry per line
   logic [tag_w-1:0]     tag_array [num_lines];
   logic [num_lines-1:0] valid_bits;
   logic [num_lines-1:0] dirty_bits;

   ctrl_state_t state;
   ctrl_state_t next_state;

   // incoming address and the held request
   addr_t             in_addr;
   addr_t             req_q;
   logic              write_q;
   logic [word_w-1:0] wdata_q;

   // refill read accepted, waiting for data
   logic rd_pend;

   logic     accept;
   logic     hit;
   logic     victim_dirty;
   logic     fill;
   mem_cmd_t mem_cmd;

   assign in_addr.raw = req_addr;
   assign accept      = req_valid && req_ready;

   // tag compare under valid
   assign hit = valid_bits[req_q.fields.index] &&
                (tag_array[req_q.fields.index] == req_q.fields.tag);

   // victim needs a write-back only if it holds modified data
   assign victim_dirty = valid_bits[req_q.fields.index] &&
                         dirty_bits[req_q.fields.index];

   // refill data lands
   assign fill = (state == allocate) && rd_pend && mem_rdata_valid;

   // next state
   always_comb begin
      next_state = state;
      case (state)
         idle: begin
            if (accept) begin
               next_state = lookup;
            end
         end
         lookup: begin
            if (hit) begin
               next_state = respond;
            end else if (victim_dirty) begin
               next_state = write_back;
            end else begin
               next_state = allocate;
            end
         end
         write_back: begin
            // held until memory takes the victim
            if (mem_req_ready) begin
               next_state = allocate;
            end
         end
         allocate: begin
            // second lookup after fill always hits
            if (fill) begin
               next_state = lookup;
            end
         end
         respond: begin
            next_state = idle;
         end
         default: begin
            next_state = idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   // refill read handshake tracking
   always_ff @(posedge clk) begin
      if (!rst) begin
         rd_pend <= 1'b0;
      end else if (fill) begin
         rd_pend <= 1'b0;
      end else if (state == allocate && !rd_pend && mem_req_ready) begin
         rd_pend <= 1'b1;
      end
   end

   // valid and dirty state
   always_ff @(posedge clk) begin
      if (!rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else begin
         if (fill) begin
            valid_bits[req_q.fields.index] <= 1'b1;
            dirty_bits[req_q.fields.index] <= 1'b0;
         end
         // write hit marks the line modified
         if (state == lookup && hit && write_q) begin
            dirty_bits[req_q.fields.index] <= 1'b1;
         end
      end
   end

   // new tag with the fill
   always_ff @(posedge clk) begin
      if (fill) begin
         tag_array[req_q.fields.index] <= req_q.fields.tag;
      end
   end

   // capture the accepted request
   always_ff @(posedge clk) begin
      if (accept) begin
         req_q.raw <= req_addr;
         write_q   <= req_write;
         wdata_q   <= req_wdata;
      end
   end

   // response word, zero for writes
   always_ff @(posedge clk) begin
      if (state == lookup && hit) begin
         if (write_q) begin
            resp_rdata <= '0;
         end else begin
            resp_rdata <= line.line_rdata[line.word_sel*word_w +: word_w];
         end
      end
   end

   assign req_ready  = (state == idle);
   assign resp_valid = (state == respond);

   // memory request, victim first then refill
   assign mem_req_valid = (state == write_back) || (state == allocate && !rd_pend);
   assign mem_cmd       = (state == write_back) ? mem_write : mem_read;
   assign mem_req_write = (mem_cmd == mem_write);

   // line aligned, victim tag during write-back
   always_comb begin
      if (state == write_back) begin
         mem_req_addr = {tag_array[req_q.fields.index], req_q.fields.index,
                         {offset_w{1'b0}}};
      end else begin
         mem_req_addr = {req_q.fields.tag, req_q.fields.index, {offset_w{1'b0}}};
      end
   end

   // index follows the bus while idle so the line is ready in lookup
   assign line.index      = (state == idle) ? in_addr.fields.index : req_q.fields.index;
   assign line.word_sel   = req_q.fields.offset[offset_w-1:2];
   assign line.word_we    = (state == lookup) && hit && write_q;
   assign line.word_wdata = wdata_q;
   assign line.fill_we    = fill;
   assign line.fill_line  = mem_rdata;

endmodule
`default_nettype wire

// ==== rtl/line_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none
/* controller to data array port */
interface line_port_if
   import cache_geom_pkg::*;
();

   // line select, held by the controller for the whole access
   logic [index_w-1:0] index;
   // word within the line
   logic [1:0]         word_sel;
   // single word write on a hit
   logic               word_we;
   logic [word_w-1:0]  word_wdata;
   // whole line refill from memory
   logic               fill_we;
   logic [line_w-1:0]  fill_line;
   // registered line, one cycle after index
   logic [line_w-1:0]  line_rdata;

   modport ctrl (
      output index, word_sel, word_we, word_wdata, fill_we, fill_line,
      input  line_rdata
   );

   modport store (
      input  index, word_sel, word_we, word_wdata, fill_we, fill_line,
      output line_rdata
   );

endinterface
`default_nettype wire

// ==== rtl/cache_ctrl_pkg.sv ====
`default_nettype none
/* controller types */
package cache_ctrl_pkg;

   // controller FSM states
   typedef enum logic [2:0] {
      idle       = 3'd0,
      lookup     = 3'd1,
      write_back = 3'd2,
      allocate   = 3'd3,
      respond    = 3'd4
   } ctrl_state_t;

   // command on the memory side
   // whole-line transfers only
   typedef enum logic {
      mem_read  = 1'b0,
      mem_write = 1'b1
   } mem_cmd_t;

endpackage
`default_nettype wire

// ==== rtl/cache_geom_pkg.sv ====
`default_nettype none
/* cache address geometry */
package cache_geom_pkg;

   // address and data widths
   localparam int addr_w = 32;
   localparam int word_w = 32;
   localparam int line_w = 128;

   // field split of a 32-bit address
   localparam int tag_w    = 20;
   localparam int index_w  = 8;
   localparam int offset_w = 4;

   // direct mapped, one line per index
   localparam int num_lines = 256;

   // tag, index and byte offset, msb first
   typedef struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
   } addr_fields_t;

   // same 32 bits, either raw or split into fields
   typedef union packed {
      logic [addr_w-1:0] raw;
      addr_fields_t      fields;
   } addr_t;

endpackage
`default_nettype wire
